// ==== rtl/exu_pkg.sv ====
package exu_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;
  localparam int CFG_AW = 2;

  // perf register map
  localparam logic [CFG_AW-1:0] CFG_ADDR_BRANCH  = 2'd0;
  localparam logic [CFG_AW-1:0] CFG_ADDR_MISPRED = 2'd1;
  localparam logic [CFG_AW-1:0] CFG_ADDR_CLEAR   = 2'd2; // write-to-clear

  typedef enum logic [3:0] {
    EXC_NONE,
    EXC_OPREG,
    EXC_OPIMM,
    EXC_LOAD,
    EXC_STORE,
    EXC_BRANCH,
    EXC_JAL,
    EXC_JALR,
    EXC_AUIPC,
    EXC_LUI
  } exc_op_e;

  // branch codes drive the comparator, ALU output is the sum then
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_BEQ, ALU_BNE,
    ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
  } alu_op_e;

  typedef enum logic [1:0] {
    JT_NONE   = 2'b00,
    JT_JAL    = 2'b01,
    JT_JALR   = 2'b10,
    JT_BRANCH = 2'b11
  } jump_type_e;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   imm;
    logic [REG_AW-1:0] rd;
    exc_op_e           exc_op;
    alu_op_e           alu_op;
    logic              pdt_taken;  // predicted direction
    logic [XLEN-1:0]   pdt_target; // predicted target
  } uop_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   alu_data;
    logic [REG_AW-1:0] rd;
    logic              is_branch;
    logic              taken;
    logic              mispredict;
    logic [XLEN-1:0]   redirect_pc;
    jump_type_e        jump_type;
  } res_t;

endpackage

// ==== rtl/exu_res_if.sv ====
`timescale 1ns/1ps

// result link from core to output queue, credit based
interface exu_res_if;
  import exu_pkg::*;

  logic valid;
  res_t res;
  logic credit; // one pulse per freed queue slot

  modport core (
    output valid,
    output res,
    input  credit
  );

  modport queue (
    input  valid,
    input  res,
    output credit
  );

endinterface

// ==== rtl/exu_credit_fifo.sv ====
`timescale 1ns/1ps

module exu_credit_fifo #(
  parameter int  DEPTH       = 4,
  parameter int  OUT_CREDITS = 1,
  parameter type PAYLOAD_T   = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     push_valid_i,
  input  PAYLOAD_T push_data_i,
  output logic     push_credit_o,
  output logic     pop_valid_o,
  output PAYLOAD_T pop_data_o,
  input  logic     pop_credit_i
);
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);
  localparam int KW = $clog2(OUT_CREDITS + 1);

  PAYLOAD_T      mem_q [DEPTH];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic [KW-1:0] cred_q; // consumer credits held
  logic          pop;

  // head goes out only with a consumer slot to land in
  assign pop           = (count_q != '0) && (cred_q != '0);
  assign pop_valid_o   = pop;
  assign pop_data_o    = mem_q[rd_ptr_q];
  assign push_credit_o = pop; // slot freed, hand credit back upstream

  always_ff @(posedge clk_i) begin
    if (push_valid_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      cred_q   <= KW'(OUT_CREDITS);
    end else begin
      if (push_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end

      case ({push_valid_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or neither
      endcase

      case ({pop, pop_credit_i})
        2'b10:   cred_q <= cred_q - 1'b1;
        2'b01:   cred_q <= cred_q + 1'b1;
        default: cred_q <= cred_q;
      endcase
    end
  end

endmodule

// ==== rtl/exu_alu.sv ====
`timescale 1ns/1ps

module exu_alu (
  input  logic [exu_pkg::XLEN-1:0] a_i,
  input  logic [exu_pkg::XLEN-1:0] b_i,
  input  exu_pkg::alu_op_e         op_i,
  output logic [exu_pkg::XLEN-1:0] out_o,
  output logic                     cmp_o
);
  import exu_pkg::*;

  logic [XLEN-1:0] sum;
  logic [4:0]      shamt;
  logic            lt_s;
  logic            lt_u;

  assign sum   = a_i + b_i;
  assign shamt = b_i[4:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    out_o = sum; // branch codes fall through to the sum
    case (op_i)
      ALU_SUB:  out_o = a_i - b_i;
      ALU_AND:  out_o = a_i & b_i;
      ALU_OR:   out_o = a_i | b_i;
      ALU_XOR:  out_o = a_i ^ b_i;
      ALU_SLL:  out_o = a_i << shamt;
      ALU_SRL:  out_o = a_i >> shamt;
      ALU_SRA:  out_o = XLEN'($signed(a_i) >>> shamt);
      ALU_SLT:  out_o = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: out_o = {{(XLEN-1){1'b0}}, lt_u};
      default:  out_o = sum;
    endcase
  end

  // branch condition
  always_comb begin
    case (op_i)
      ALU_BEQ:  cmp_o = (a_i == b_i);
      ALU_BNE:  cmp_o = (a_i != b_i);
      ALU_BLT:  cmp_o = lt_s;
      ALU_BGE:  cmp_o = !lt_s;
      ALU_BLTU: cmp_o = lt_u;
      ALU_BGEU: cmp_o = !lt_u;
      default:  cmp_o = 1'b0;
    endcase
  end

endmodule

// ==== rtl/exu_branch_unit.sv ====
`timescale 1ns/1ps

module exu_branch_unit (
  input  exu_pkg::uop_t            uop_i,
  input  logic                     cmp_i,
  output logic                     is_branch_o,
  output logic                     taken_o,
  output logic                     mispredict_o,
  output logic [exu_pkg::XLEN-1:0] redirect_pc_o,
  output exu_pkg::jump_type_e      jump_type_o
);
  import exu_pkg::*;

  logic            is_br;
  logic            is_jal;
  logic            is_jalr;
  logic [XLEN-1:0] pc_imm;
  logic [XLEN-1:0] rs1_imm;
  logic [XLEN-1:0] target;
  logic            target_hit;

  assign is_br   = (uop_i.exc_op == EXC_BRANCH);
  assign is_jal  = (uop_i.exc_op == EXC_JAL);
  assign is_jalr = (uop_i.exc_op == EXC_JALR);

  assign pc_imm  = uop_i.pc + uop_i.imm;
  assign rs1_imm = uop_i.rs1_data + uop_i.imm;
  assign target  = is_jalr ? {rs1_imm[XLEN-1:1], 1'b0} : pc_imm;

  assign is_branch_o = is_br | is_jal | is_jalr;
  assign taken_o     = (is_br & cmp_i) | is_jal | is_jalr;

  // right direction can still carry a stale target
  assign target_hit   = (target == uop_i.pdt_target);
  assign mispredict_o = (taken_o != uop_i.pdt_taken) ||
                        (taken_o && uop_i.pdt_taken && !target_hit);

  // predicted taken but fell through, back to the next sequential pc
  assign redirect_pc_o = (uop_i.pdt_taken && !taken_o) ? uop_i.pc + XLEN'(4) : target;

  always_comb begin
    if (is_jal) begin
      jump_type_o = JT_JAL;
    end else if (is_jalr) begin
      jump_type_o = JT_JALR;
    end else if (is_br) begin
      jump_type_o = JT_BRANCH;
    end else begin
      jump_type_o = JT_NONE;
    end
  end

endmodule

// ==== rtl/exu_core.sv ====
`timescale 1ns/1ps

module exu_core #(
  parameter int OUT_DEPTH = 4
) (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          in_valid_i,
  input  exu_pkg::uop_t in_uop_i,
  output logic          in_credit_o,
  exu_res_if.core       res_o,
  output logic          branch_done_o,
  output logic          mispredict_o
);
  import exu_pkg::*;

  localparam int KW = $clog2(OUT_DEPTH + 1);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] upper_imm;
  logic [XLEN-1:0] alu_out;
  logic            cmp;
  logic            is_branch;
  logic            taken;
  logic            mispredict;
  logic [XLEN-1:0] redirect_pc;
  jump_type_e      jump_type;
  res_t            res_q;   // single result slot
  logic            full_q;
  logic [KW-1:0]   cred_q;  // free output queue slots
  logic            fire;

  assign upper_imm = {in_uop_i.imm[XLEN-1:12], 12'b0};

  // operand select by execute class
  always_comb begin
    op_a = '0;
    op_b = '0;
    case (in_uop_i.exc_op)
      EXC_OPREG, EXC_BRANCH: begin
        op_a = in_uop_i.rs1_data;
        op_b = in_uop_i.rs2_data;
      end
      EXC_OPIMM, EXC_LOAD, EXC_STORE: begin
        op_a = in_uop_i.rs1_data;
        op_b = in_uop_i.imm;
      end
      EXC_JAL, EXC_JALR: begin
        op_a = in_uop_i.pc; // link value
        op_b = XLEN'(4);
      end
      EXC_AUIPC: begin
        op_a = in_uop_i.pc;
        op_b = upper_imm;
      end
      EXC_LUI: op_b = upper_imm; // zero plus upper imm
      default: begin
        op_a = '0;
        op_b = '0;
      end
    endcase
  end

  exu_alu i_alu (
    .a_i   (op_a),
    .b_i   (op_b),
    .op_i  (in_uop_i.alu_op),
    .out_o (alu_out),
    .cmp_o (cmp)
  );

  exu_branch_unit i_branch_unit (
    .uop_i         (in_uop_i),
    .cmp_i         (cmp),
    .is_branch_o   (is_branch),
    .taken_o       (taken),
    .mispredict_o  (mispredict),
    .redirect_pc_o (redirect_pc),
    .jump_type_o   (jump_type)
  );

  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      res_q.pc          <= in_uop_i.pc;
      res_q.alu_data    <= alu_out;
      res_q.rd          <= in_uop_i.rd;
      res_q.is_branch   <= is_branch;
      res_q.taken       <= taken;
      res_q.mispredict  <= mispredict;
      res_q.redirect_pc <= redirect_pc;
      res_q.jump_type   <= jump_type;
    end
  end

  // hand off only with an output slot free, else hold
  assign fire        = full_q && (cred_q != '0);
  assign res_o.valid = fire;
  assign res_o.res   = res_q;
  assign in_credit_o = fire; // slot is free again

  assign branch_done_o = fire && res_q.is_branch;
  assign mispredict_o  = fire && res_q.mispredict;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
      cred_q <= KW'(OUT_DEPTH);
    end else begin
      if (in_valid_i) begin
        full_q <= 1'b1;
      end else if (fire) begin
        full_q <= 1'b0;
      end

      case ({fire, res_o.credit})
        2'b10:   cred_q <= cred_q - 1'b1;
        2'b01:   cred_q <= cred_q + 1'b1;
        default: cred_q <= cred_q;
      endcase
    end
  end

endmodule

// ==== rtl/exu_perf_regs.sv ====
`timescale 1ns/1ps

module exu_perf_regs (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       branch_done_i,
  input  logic                       mispredict_i,
  input  logic [exu_pkg::CFG_AW-1:0] cfg_addr_i,
  input  logic                       cfg_we_i,
  output logic [exu_pkg::XLEN-1:0]   cfg_rdata_o
);
  import exu_pkg::*;

  logic [XLEN-1:0] branch_cnt_q;
  logic [XLEN-1:0] mispred_cnt_q;
  logic            clear;

  assign clear = cfg_we_i && (cfg_addr_i == CFG_ADDR_CLEAR);

  // counters stick at all ones
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      branch_cnt_q  <= '0;
      mispred_cnt_q <= '0;
    end else if (clear) begin
      branch_cnt_q  <= '0;
      mispred_cnt_q <= '0;
    end else begin
      if (branch_done_i && (branch_cnt_q != '1)) begin
        branch_cnt_q <= branch_cnt_q + 1'b1;
      end
      if (mispredict_i && (mispred_cnt_q != '1)) begin
        mispred_cnt_q <= mispred_cnt_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (cfg_addr_i)
      CFG_ADDR_BRANCH:  cfg_rdata_o = branch_cnt_q;
      CFG_ADDR_MISPRED: cfg_rdata_o = mispred_cnt_q;
      default:          cfg_rdata_o = '0; // clear reg reads zero
    endcase
  end

endmodule

// ==== rtl/exu_top.sv ====
`timescale 1ns/1ps

module exu_top #(
  parameter int IN_DEPTH    = 4,
  parameter int OUT_DEPTH   = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // micro-op in
  input  logic                         uop_valid_i,
  input  logic [exu_pkg::XLEN-1:0]     pc_i,
  input  logic [exu_pkg::XLEN-1:0]     rs1_data_i,
  input  logic [exu_pkg::XLEN-1:0]     rs2_data_i,
  input  logic [exu_pkg::XLEN-1:0]     imm_i,
  input  logic [exu_pkg::REG_AW-1:0]   rd_i,
  input  exu_pkg::exc_op_e             exc_op_i,
  input  exu_pkg::alu_op_e             alu_op_i,
  input  logic                         pdt_taken_i,
  input  logic [exu_pkg::XLEN-1:0]     pdt_target_i,
  output logic                         uop_credit_o,
  // result out
  output logic                         result_valid_o,
  output logic [exu_pkg::XLEN-1:0]     pc_o,
  output logic [exu_pkg::XLEN-1:0]     alu_data_o,
  output logic [exu_pkg::REG_AW-1:0]   rd_o,
  output logic                         is_branch_o,
  output logic                         taken_o,
  output logic                         mispredict_o,
  output logic [exu_pkg::XLEN-1:0]     redirect_pc_o,
  output exu_pkg::jump_type_e          jump_type_o,
  input  logic                         result_credit_i,
  // perf register port
  input  logic [exu_pkg::CFG_AW-1:0]   cfg_addr_i,
  input  logic                         cfg_we_i,
  output logic [exu_pkg::XLEN-1:0]     cfg_rdata_o
);
  import exu_pkg::*;

  uop_t in_uop;
  uop_t core_uop;
  logic core_valid;
  logic core_credit;
  res_t out_res;
  logic branch_done;
  logic branch_mispred;

  exu_res_if res_link ();

  assign in_uop.pc         = pc_i;
  assign in_uop.rs1_data   = rs1_data_i;
  assign in_uop.rs2_data   = rs2_data_i;
  assign in_uop.imm        = imm_i;
  assign in_uop.rd         = rd_i;
  assign in_uop.exc_op     = exc_op_i;
  assign in_uop.alu_op     = alu_op_i;
  assign in_uop.pdt_taken  = pdt_taken_i;
  assign in_uop.pdt_target = pdt_target_i;

  // core holds one item, so one consumer credit
  exu_credit_fifo #(
    .DEPTH       (IN_DEPTH),
    .OUT_CREDITS (1),
    .PAYLOAD_T   (uop_t)
  ) i_in_fifo (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .push_valid_i  (uop_valid_i),
    .push_data_i   (in_uop),
    .push_credit_o (uop_credit_o),
    .pop_valid_o   (core_valid),
    .pop_data_o    (core_uop),
    .pop_credit_i  (core_credit)
  );

  exu_core #(
    .OUT_DEPTH (OUT_DEPTH)
  ) i_core (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .in_valid_i    (core_valid),
    .in_uop_i      (core_uop),
    .in_credit_o   (core_credit),
    .res_o         (res_link.core),
    .branch_done_o (branch_done),
    .mispredict_o  (branch_mispred)
  );

  exu_perf_regs i_perf_regs (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .branch_done_i (branch_done),
    .mispredict_i  (branch_mispred),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_rdata_o   (cfg_rdata_o)
  );

  exu_credit_fifo #(
    .DEPTH       (OUT_DEPTH),
    .OUT_CREDITS (OUT_CREDITS),
    .PAYLOAD_T   (res_t)
  ) i_out_fifo (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .push_valid_i  (res_link.valid),
    .push_data_i   (res_link.res),
    .push_credit_o (res_link.credit),
    .pop_valid_o   (result_valid_o),
    .pop_data_o    (out_res),
    .pop_credit_i  (result_credit_i)
  );

  assign pc_o          = out_res.pc;
  assign alu_data_o    = out_res.alu_data;
  assign rd_o          = out_res.rd;
  assign is_branch_o   = out_res.is_branch;
  assign taken_o       = out_res.taken;
  assign mispredict_o  = out_res.mispredict;
  assign redirect_pc_o = out_res.redirect_pc;
  assign jump_type_o   = out_res.jump_type;

endmodule

// ==== dv/exu_tb_clk.sv ====
`timescale 1ns/1ps

module exu_tb_clk #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o; // 50/50 duty
  end

endmodule

// ==== dv/exu_props.sv ====
`timescale 1ns/1ps

module exu_props #(
  parameter int OUT_CREDITS = 2
) (
  input logic                     clk_i,
  input logic                     arst_n_i,
  input logic                     uop_valid_i,
  input logic                     uop_credit_i,
  input logic                     result_valid_i,
  input logic                     result_credit_i,
  input logic [exu_pkg::XLEN-1:0] redirect_pc_i,
  input exu_pkg::jump_type_e      jump_type_i
);
  import exu_pkg::*;

  int unsigned fail_cnt = 0;   // collected by the testbench
  logic [7:0]  in_held_q;      // micro-ops inside the input queue
  logic [7:0]  out_cred_q;     // downstream credits still held by the DUT

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_held_q  <= '0;
      out_cred_q <= 8'(OUT_CREDITS);
    end else begin
      in_held_q  <= in_held_q + 8'(uop_valid_i) - 8'(uop_credit_i);
      out_cred_q <= out_cred_q - 8'(result_valid_i) + 8'(result_credit_i);
    end
  end

  a_credit_after_accept : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    uop_credit_i |-> (in_held_q != '0))
    else begin
      $error("uop_credit_o pulsed with no micro-op held in the input queue");
      fail_cnt++;
    end

  a_valid_within_credit : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_i |-> (out_cred_q != '0))
    else begin
      $error("result_valid_o raised without a downstream credit");
      fail_cnt++;
    end

  // jalr target drops bit 0
  a_jalr_even_redirect : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (result_valid_i && (jump_type_i == JT_JALR)) |-> !redirect_pc_i[0])
    else begin
      $error("odd redirect_pc_o on a jalr result");
      fail_cnt++;
    end

endmodule

bind exu_top exu_props #(
  .OUT_CREDITS (OUT_CREDITS)
) i_props (
  .clk_i           (clk_i),
  .arst_n_i        (arst_n_i),
  .uop_valid_i     (uop_valid_i),
  .uop_credit_i    (uop_credit_o),
  .result_valid_i  (result_valid_o),
  .result_credit_i (result_credit_i),
  .redirect_pc_i   (redirect_pc_o),
  .jump_type_i     (jump_type_o)
);

// ==== dv/exu_tb.sv ====
`timescale 1ns/1ps

module exu_tb;
  import exu_pkg::*;

  localparam int IN_DEPTH       = 4;
  localparam int OUT_DEPTH      = 4;
  localparam int OUT_CREDITS    = 2;
  localparam int RESET_CYCLES   = 16;
  localparam int N_UOPS         = 300;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + (N_UOPS + 1) * 40; // extra slot for perf reads

  logic              clk;
  logic              arst_n;
  logic              uop_valid;
  uop_t              drv_uop;
  logic              uop_credit;
  logic              result_valid;
  res_t              dut_res;
  logic              result_credit;
  logic [CFG_AW-1:0] cfg_addr;
  logic              cfg_we;
  logic [XLEN-1:0]   cfg_rdata;

  logic [31:0] lfsr;
  res_t        exp_q [$];
  res_t        exp_res;
  int          n_sent;
  int          n_recv;
  int          n_credit_back;  // uop_credit_o pulses seen
  int          n_credit_ret;   // result credits handed back
  int          n_branch;
  int          n_mispred;
  int          n_checks;
  int          n_errors;
  int          cycle_cnt;

  exu_tb_clk #(.PERIOD_NS(100)) i_clk (.clk_o(clk));

  exu_top #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_DEPTH   (OUT_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) i_dut (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .uop_valid_i     (uop_valid),
    .pc_i            (drv_uop.pc),
    .rs1_data_i      (drv_uop.rs1_data),
    .rs2_data_i      (drv_uop.rs2_data),
    .imm_i           (drv_uop.imm),
    .rd_i            (drv_uop.rd),
    .exc_op_i        (drv_uop.exc_op),
    .alu_op_i        (drv_uop.alu_op),
    .pdt_taken_i     (drv_uop.pdt_taken),
    .pdt_target_i    (drv_uop.pdt_target),
    .uop_credit_o    (uop_credit),
    .result_valid_o  (result_valid),
    .pc_o            (dut_res.pc),
    .alu_data_o      (dut_res.alu_data),
    .rd_o            (dut_res.rd),
    .is_branch_o     (dut_res.is_branch),
    .taken_o         (dut_res.taken),
    .mispredict_o    (dut_res.mispredict),
    .redirect_pc_o   (dut_res.redirect_pc),
    .jump_type_o     (dut_res.jump_type),
    .result_credit_i (result_credit),
    .cfg_addr_i      (cfg_addr),
    .cfg_we_i        (cfg_we),
    .cfg_rdata_o     (cfg_rdata)
  );

  // galois lfsr, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [XLEN-1:0] jump_target(input uop_t u);
    logic [XLEN-1:0] t;
    if (u.exc_op == EXC_JALR) begin
      t    = u.rs1_data + u.imm;
      t[0] = 1'b0;
    end else begin
      t = u.pc + u.imm;
    end
    return t;
  endfunction

  function automatic res_t ref_result(input uop_t u);
    res_t            r;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] tgt;
    logic [4:0]      sh;
    logic            lt;
    logic            ltu;
    logic            cond;
    a = '0;
    b = '0;
    case (u.exc_op)
      EXC_OPREG, EXC_BRANCH: begin
        a = u.rs1_data;
        b = u.rs2_data;
      end
      EXC_OPIMM, EXC_LOAD, EXC_STORE: begin
        a = u.rs1_data;
        b = u.imm;
      end
      EXC_JAL, EXC_JALR: begin
        a = u.pc;
        b = 32'd4;
      end
      EXC_AUIPC: begin
        a = u.pc;
        b = u.imm & 32'hffff_f000;
      end
      EXC_LUI: b = u.imm & 32'hffff_f000;
      default: b = '0;
    endcase
    sh  = b[4:0];
    ltu = a < b;
    lt  = (a[31] != b[31]) ? a[31] : ltu; // sign bits differ, negative one is less
    case (u.alu_op)
      ALU_SUB:  r.alu_data = a - b;
      ALU_AND:  r.alu_data = a & b;
      ALU_OR:   r.alu_data = a | b;
      ALU_XOR:  r.alu_data = a ^ b;
      ALU_SLL:  r.alu_data = a << sh;
      ALU_SRL:  r.alu_data = a >> sh;
      ALU_SRA:  r.alu_data = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      ALU_SLT:  r.alu_data = {31'b0, lt};
      ALU_SLTU: r.alu_data = {31'b0, ltu};
      default:  r.alu_data = a + b;
    endcase
    case (u.alu_op)
      ALU_BEQ, ALU_BNE: cond = (a == b);
      ALU_BLT, ALU_BGE: cond = lt;
      default:          cond = ltu;
    endcase
    cond = cond ^ u.alu_op[0]; // odd codes are the negated tests
    tgt  = jump_target(u);

    r.pc          = u.pc;
    r.rd          = u.rd;
    r.is_branch   = (u.exc_op == EXC_BRANCH) || (u.exc_op == EXC_JAL) || (u.exc_op == EXC_JALR);
    r.taken       = (u.exc_op == EXC_BRANCH) ? cond : r.is_branch;
    r.mispredict  = (r.taken != u.pdt_taken) || (r.taken && (tgt != u.pdt_target));
    r.redirect_pc = (u.pdt_taken && !r.taken) ? u.pc + 32'd4 : tgt;
    case (u.exc_op)
      EXC_JAL:    r.jump_type = JT_JAL;
      EXC_JALR:   r.jump_type = JT_JALR;
      EXC_BRANCH: r.jump_type = JT_BRANCH;
      default:    r.jump_type = JT_NONE;
    endcase
    return r;
  endfunction

  function automatic uop_t make_uop();
    uop_t       u;
    logic [2:0] kind;
    kind        = 3'(take_bits(3));
    u.pc        = take_bits(32) & ~32'h3;
    u.rs1_data  = take_bits(32);
    u.rs2_data  = (take_bits(1) != 0) ? u.rs1_data : take_bits(32); // equal operands now and then
    u.imm       = take_bits(32);
    u.rd        = 5'(take_bits(5));
    u.alu_op    = ALU_ADD;
    u.pdt_taken = 1'b0;
    case (kind)
      3'd0: begin
        u.exc_op = EXC_OPREG;
        u.alu_op = alu_op_e'(4'(take_bits(4) % 10));
      end
      3'd1: begin
        u.exc_op = EXC_OPIMM;
        u.alu_op = alu_op_e'(4'(take_bits(4) % 10));
      end
      3'd2, 3'd3: begin
        u.exc_op = EXC_BRANCH;
        u.alu_op = alu_op_e'(4'(10 + take_bits(3) % 6));
      end
      3'd4:    u.exc_op = EXC_JAL;
      3'd5:    u.exc_op = EXC_JALR;
      3'd6:    u.exc_op = EXC_AUIPC;
      default: u.exc_op = EXC_LUI;
    endcase
    u.pdt_target = u.pc + 32'd4;
    if (kind inside {3'd2, 3'd3, 3'd4, 3'd5}) begin
      u.pdt_taken  = take_bits(1) != 0;
      // a quarter of predictions point 4 bytes off
      u.pdt_target = (take_bits(2) != 0) ? jump_target(u) : jump_target(u) + 32'd4;
    end
    return u;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic read_perf(input logic [CFG_AW-1:0] addr, output logic [XLEN-1:0] data);
    @(posedge clk);
    #1;
    cfg_addr = addr;
    @(negedge clk);
    data = cfg_rdata; // read port is combinational
  endtask

  task automatic clear_perf();
    @(posedge clk);
    #1;
    cfg_addr = CFG_ADDR_CLEAR;
    cfg_we   = 1'b1;
    @(posedge clk);
    #1;
    cfg_we   = 1'b0;
  endtask

  initial begin : main
    uop_t            u;
    res_t            r;
    logic [XLEN-1:0] val;
    lfsr      = 32'd71846;
    arst_n    = 1'b0;
    uop_valid = 1'b0;
    drv_uop   = '0;
    cfg_addr  = CFG_ADDR_BRANCH;
    cfg_we    = 1'b0;
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check("uop_credit_o", 32'(uop_credit), 32'h0);
    check("result_valid_o", 32'(result_valid), 32'h0);
    check("cfg_rdata_o", cfg_rdata, 32'h0);
    @(posedge clk);
    #1;
    arst_n = 1'b1;

    while (n_sent < N_UOPS) begin
      @(posedge clk);
      #1;
      if ((IN_DEPTH + n_credit_back - n_sent > 0) && (take_bits(2) != 0)) begin
        u = make_uop();
        r = ref_result(u);
        exp_q.push_back(r);
        if (r.is_branch) begin
          n_branch++;
        end
        if (r.mispredict) begin
          n_mispred++;
        end
        drv_uop   = u;
        uop_valid = 1'b1;
        n_sent++;
      end else begin
        uop_valid = 1'b0;
      end
    end
    @(posedge clk);
    #1;
    uop_valid = 1'b0;
    while (n_recv < N_UOPS) @(posedge clk);

    read_perf(CFG_ADDR_BRANCH, val);
    check("cfg_rdata_o (branch count)", val, 32'(n_branch));
    read_perf(CFG_ADDR_MISPRED, val);
    check("cfg_rdata_o (mispredict count)", val, 32'(n_mispred));
    clear_perf();
    read_perf(CFG_ADDR_BRANCH, val);
    check("cfg_rdata_o (branch count)", val, 32'h0);
    read_perf(CFG_ADDR_MISPRED, val);
    check("cfg_rdata_o (mispredict count)", val, 32'h0);

    if (i_dut.i_props.fail_cnt != 0) begin
      n_errors += int'(i_dut.i_props.fail_cnt);
      $display("bound assertions failed %0d times", i_dut.i_props.fail_cnt);
    end
    $display("checks: %0d  errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // outputs come from flops, so mid-cycle sampling is stable
  initial begin : monitor
    forever begin
      @(negedge clk);
      if (arst_n) begin
        if (uop_credit) begin
          n_credit_back++;
          if (n_credit_back > n_sent) begin
            n_errors++;
            $display("input queue returned more credits than micro-ops were sent");
          end
        end
        if (result_valid) begin
          n_recv++;
          if (exp_q.size() == 0) begin
            n_errors++;
            $display("result arrived while no micro-op was outstanding");
          end else begin
            exp_res = exp_q.pop_front();
            check("pc_o", dut_res.pc, exp_res.pc);
            check("alu_data_o", dut_res.alu_data, exp_res.alu_data);
            check("rd_o", 32'(dut_res.rd), 32'(exp_res.rd));
            check("is_branch_o", 32'(dut_res.is_branch), 32'(exp_res.is_branch));
            check("taken_o", 32'(dut_res.taken), 32'(exp_res.taken));
            check("mispredict_o", 32'(dut_res.mispredict), 32'(exp_res.mispredict));
            check("redirect_pc_o", dut_res.redirect_pc, exp_res.redirect_pc);
            check("jump_type_o", 32'(dut_res.jump_type), 32'(exp_res.jump_type));
          end
        end
      end
    end
  end

  // downstream sink, goes quiet for 64 of every 160 cycles
  initial begin : credit_return
    result_credit = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (arst_n && (n_recv > n_credit_ret) && (cycle_cnt % 160 < 96)) begin
        result_credit = 1'b1;
        n_credit_ret++;
      end else begin
        result_credit = 1'b0;
      end
    end
  end

  initial begin : watchdog
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, %0d of %0d results seen", cycle_cnt, n_recv, N_UOPS);
    $display("checks: %0d  errors: %0d", n_checks, n_errors);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== compile.f ====
rtl/exu_pkg.sv
rtl/exu_res_if.sv
rtl/exu_credit_fifo.sv
rtl/exu_alu.sv
rtl/exu_branch_unit.sv
rtl/exu_core.sv
rtl/exu_perf_regs.sv
rtl/exu_top.sv
dv/exu_tb_clk.sv
dv/exu_props.sv
dv/exu_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module exu_tb -f compile.f
	out=$$(./obj_dir/Vexu_tb); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
